//--- hdl/lsu_macros.svh
`ifndef LSU_MACROS_SVH
`define LSU_MACROS_SVH

// data path and address width
`define LSU_XLEN        64
// byte offset inside one double
`define LSU_OFS_W       3
`define LSU_STRB_W      8

// ********************************************************************
// bus response codes
// ********************************************************************
`define LSU_RESP_OKAY           2'd0
`define LSU_RESP_PAGE_ERR       2'd2
`define LSU_RESP_ACCESS_ERR     2'd3

// ********************************************************************
// trap cause codes
// ********************************************************************
`define LSU_CAUSE_LOAD_MISALIGN     64'd4
`define LSU_CAUSE_LOAD_ACCESS       64'd5
`define LSU_CAUSE_STORE_MISALIGN    64'd6
`define LSU_CAUSE_STORE_ACCESS      64'd7
`define LSU_CAUSE_LOAD_PAGE         64'd13
`define LSU_CAUSE_STORE_PAGE        64'd15

`endif

//--- hdl/lsu_pkg.sv
`default_nettype none

`include "lsu_macros.svh"

package lsu_pkg;

    // encoding matches the bus size field
    typedef enum logic [1:0] {
        SIZE_BYTE   = 2'd0,
        SIZE_HALF   = 2'd1,
        SIZE_WORD   = 2'd2,
        SIZE_DOUBLE = 2'd3
    } mem_size_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   pc;
        logic [4:0]             rd;
        logic                   dest_wen;
        logic                   is_load;
        logic                   is_store;
        mem_size_t              size;
        logic                   is_signed;
        // address for memory ops, result otherwise
        logic [`LSU_XLEN-1:0]   operand;
        logic [`LSU_XLEN-1:0]   store_data;
    } lsu_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        mem_size_t              size;
    } rd_addr_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   addr;
        mem_size_t              size;
        logic [`LSU_STRB_W-1:0] strb;
        logic [`LSU_XLEN-1:0]   data;
    } wr_req_t;

    typedef struct packed {
        logic [`LSU_XLEN-1:0]   pc;
        logic [4:0]             rd;
        logic                   dest_wen;
        logic                   trap_valid;
        logic [`LSU_XLEN-1:0]   trap_cause;
        logic [`LSU_XLEN-1:0]   trap_tval;
        logic [`LSU_XLEN-1:0]   data;
    } lsu_wb_t;

    typedef struct packed {
        logic page_err;
        logic access_err;
    } bus_err_t;

endpackage

`default_nettype wire

//--- hdl/lsu_exception_unit.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_exception_unit (
    input  wire lsu_pkg::lsu_req_t      req,
    input  wire                         ex_valid,
    input  wire lsu_pkg::bus_err_t      load_err,
    input  wire lsu_pkg::bus_err_t      store_err,
    output logic                        misaligned,
    output logic                        trap_valid,
    output logic [`LSU_XLEN-1:0]        trap_cause,
    output logic [`LSU_XLEN-1:0]        trap_tval
);
    import lsu_pkg::*;

    logic addr_unaligned;

    always_comb begin
        case (req.size)
            SIZE_HALF:   addr_unaligned = req.operand[0];
            SIZE_WORD:   addr_unaligned = |req.operand[1:0];
            SIZE_DOUBLE: addr_unaligned = |req.operand[`LSU_OFS_W-1:0];
            default:     addr_unaligned = 1'b0;
        endcase
    end

    assign misaligned = (req.is_load | req.is_store) & addr_unaligned;

    assign trap_valid = ex_valid & (misaligned |
                                    load_err.page_err | load_err.access_err |
                                    store_err.page_err | store_err.access_err);

    // load side wins over store side
    always_comb begin
        trap_cause = '0;
        if (misaligned && req.is_load)         trap_cause = `LSU_CAUSE_LOAD_MISALIGN;
        else if (load_err.page_err)            trap_cause = `LSU_CAUSE_LOAD_PAGE;
        else if (load_err.access_err)          trap_cause = `LSU_CAUSE_LOAD_ACCESS;
        else if (misaligned && req.is_store)   trap_cause = `LSU_CAUSE_STORE_MISALIGN;
        else if (store_err.access_err)         trap_cause = `LSU_CAUSE_STORE_ACCESS;
        else if (store_err.page_err)           trap_cause = `LSU_CAUSE_STORE_PAGE;
    end

    assign trap_tval = trap_valid ? req.operand : '0;

endmodule

`default_nettype wire

//--- hdl/lsu_load_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_load_path (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         ex_valid,
    input  wire lsu_pkg::lsu_req_t      req,
    input  wire                         misaligned,
    input  wire                         accept,
    input  wire                         ar_ready,
    input  wire                         r_valid,
    input  wire [1:0]                   r_resp,
    input  wire [`LSU_XLEN-1:0]         r_data,
    output logic                        ar_valid,
    output lsu_pkg::rd_addr_t           ar,
    output logic                        load_done,
    output logic [`LSU_XLEN-1:0]        load_data,
    output lsu_pkg::bus_err_t           load_err
);
    import lsu_pkg::*;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_WAIT_AR,
        RD_WAIT_R,
        RD_HOLD
    } rd_state_t;

    rd_state_t              state;
    logic [`LSU_XLEN-1:0]   lane;
    logic [`LSU_XLEN-1:0]   extended;

    assign ar.addr = req.operand;
    assign ar.size = req.size;

    // **********************************************************************
    // lane extraction
    // **********************************************************************
    assign lane = r_data >> {req.operand[`LSU_OFS_W-1:0], 3'b000};

    always_comb begin
        case (req.size)
            SIZE_BYTE: extended = {{(`LSU_XLEN-8){req.is_signed & lane[7]}}, lane[7:0]};
            SIZE_HALF: extended = {{(`LSU_XLEN-16){req.is_signed & lane[15]}}, lane[15:0]};
            SIZE_WORD: extended = {{(`LSU_XLEN-32){req.is_signed & lane[31]}}, lane[31:0]};
            default:   extended = lane;
        endcase
    end

    // **********************************************************************
    // read channel fsm
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= RD_IDLE;
            ar_valid  <= 1'b0;
            load_done <= 1'b0;
            load_err  <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (ex_valid && req.is_load && !misaligned) begin
                        state    <= RD_WAIT_AR;
                        ar_valid <= 1'b1;
                    end
                end
                RD_WAIT_AR: begin
                    if (ar_ready) begin
                        state    <= RD_WAIT_R;
                        ar_valid <= 1'b0;
                    end
                end
                RD_WAIT_R: begin
                    if (r_valid) begin
                        state               <= RD_HOLD;
                        load_done           <= 1'b1;
                        load_err.page_err   <= (r_resp == `LSU_RESP_PAGE_ERR);
                        load_err.access_err <= (r_resp == `LSU_RESP_ACCESS_ERR);
                    end
                end
                RD_HOLD: begin
                    // held until the commit stage takes the result
                    if (accept) begin
                        state     <= RD_IDLE;
                        load_done <= 1'b0;
                        load_err  <= '0;
                    end
                end
                default: begin
                    state    <= RD_IDLE;
                    ar_valid <= 1'b0;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RD_WAIT_R && r_valid) begin
            load_data <= extended;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lsu_store_path.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_store_path (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         ex_valid,
    input  wire lsu_pkg::lsu_req_t      req,
    input  wire                         misaligned,
    input  wire                         accept,
    input  wire                         aw_ready,
    input  wire                         w_ready,
    input  wire                         b_valid,
    input  wire [1:0]                   b_resp,
    output logic                        aw_valid,
    output logic                        w_valid,
    output lsu_pkg::wr_req_t            wr,
    output logic                        store_done,
    output lsu_pkg::bus_err_t           store_err
);
    import lsu_pkg::*;

    typedef enum logic [2:0] {
        WR_IDLE,
        WR_WAIT_BOTH,
        WR_WAIT_AW,
        WR_WAIT_W,
        WR_WAIT_B,
        WR_HOLD
    } wr_state_t;

    wr_state_t                  state;
    logic [`LSU_STRB_W-1:0]     size_mask;
    logic [`LSU_OFS_W-1:0]      offset;

    assign offset = req.operand[`LSU_OFS_W-1:0];

    // **********************************************************************
    // strobes and lane placement
    // **********************************************************************
    always_comb begin
        case (req.size)
            SIZE_BYTE: size_mask = 8'h01;
            SIZE_HALF: size_mask = 8'h03;
            SIZE_WORD: size_mask = 8'h0f;
            default:   size_mask = 8'hff;
        endcase
    end

    assign wr.addr = req.operand;
    assign wr.size = req.size;
    assign wr.strb = size_mask << offset;
    assign wr.data = req.store_data << {offset, 3'b000};

    // **********************************************************************
    // write channel fsm
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= WR_IDLE;
            aw_valid   <= 1'b0;
            w_valid    <= 1'b0;
            store_done <= 1'b0;
            store_err  <= '0;
        end else begin
            case (state)
                WR_IDLE: begin
                    if (ex_valid && req.is_store && !misaligned) begin
                        state    <= WR_WAIT_BOTH;
                        aw_valid <= 1'b1;
                        w_valid  <= 1'b1;
                    end
                end
                WR_WAIT_BOTH: begin
                    // address and data may finish in either order
                    if (aw_ready && w_ready) begin
                        state    <= WR_WAIT_B;
                        aw_valid <= 1'b0;
                        w_valid  <= 1'b0;
                    end else if (aw_ready) begin
                        state    <= WR_WAIT_W;
                        aw_valid <= 1'b0;
                    end else if (w_ready) begin
                        state    <= WR_WAIT_AW;
                        w_valid  <= 1'b0;
                    end
                end
                WR_WAIT_AW: begin
                    if (aw_ready) begin
                        state    <= WR_WAIT_B;
                        aw_valid <= 1'b0;
                    end
                end
                WR_WAIT_W: begin
                    if (w_ready) begin
                        state   <= WR_WAIT_B;
                        w_valid <= 1'b0;
                    end
                end
                WR_WAIT_B: begin
                    if (b_valid) begin
                        state                <= WR_HOLD;
                        store_done           <= 1'b1;
                        store_err.page_err   <= (b_resp == `LSU_RESP_PAGE_ERR);
                        store_err.access_err <= (b_resp == `LSU_RESP_ACCESS_ERR);
                    end
                end
                WR_HOLD: begin
                    if (accept) begin
                        state      <= WR_IDLE;
                        store_done <= 1'b0;
                        store_err  <= '0;
                    end
                end
                default: begin
                    state    <= WR_IDLE;
                    aw_valid <= 1'b0;
                    w_valid  <= 1'b0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/lsu_commit_stage.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_commit_stage (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         ex_valid,
    input  wire lsu_pkg::lsu_req_t      req,
    input  wire                         load_done,
    input  wire [`LSU_XLEN-1:0]         load_data,
    input  wire                         store_done,
    input  wire                         trap_valid,
    input  wire [`LSU_XLEN-1:0]         trap_cause,
    input  wire [`LSU_XLEN-1:0]         trap_tval,
    input  wire                         wb_ready,
    input  wire                         wb_flush,
    output logic                        ex_ready,
    output logic                        wb_valid,
    output lsu_pkg::lsu_wb_t            wb
);

    logic can_advance;
    logic op_done;

    assign can_advance = !wb_valid || wb_ready;

    // pass-through ops finish at once
    assign op_done = req.is_load  ? load_done  :
                     req.is_store ? store_done : 1'b1;

    assign ex_ready = ex_valid && can_advance && (trap_valid || op_done);

    // **********************************************************************
    // writeback register
    // **********************************************************************
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_valid <= 1'b0;
        end else if (wb_flush) begin
            wb_valid <= 1'b0;
        end else if (can_advance) begin
            wb_valid <= ex_ready;
        end
    end

    always_ff @(posedge clk) begin
        if (ex_ready) begin
            wb.pc         <= req.pc;
            wb.rd         <= req.rd;
            wb.dest_wen   <= req.dest_wen;
            wb.trap_valid <= trap_valid;
            wb.trap_cause <= trap_cause;
            wb.trap_tval  <= trap_tval;
            wb.data       <= req.is_load ? load_data : req.operand;
        end
    end

endmodule

`default_nettype wire

//--- hdl/lsu.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu (
    input  wire                         clk,
    input  wire                         rst_n,
    // execute side
    input  wire                         ex_valid,
    input  wire lsu_pkg::lsu_req_t      ex_req,
    output logic                        ex_ready,
    // read channels
    output logic                        ar_valid,
    input  wire                         ar_ready,
    output lsu_pkg::rd_addr_t           ar,
    input  wire                         r_valid,
    input  wire [1:0]                   r_resp,
    input  wire [`LSU_XLEN-1:0]         r_data,
    // write channels
    output logic                        aw_valid,
    input  wire                         aw_ready,
    output logic                        w_valid,
    input  wire                         w_ready,
    output lsu_pkg::wr_req_t            wr,
    input  wire                         b_valid,
    input  wire [1:0]                   b_resp,
    // writeback side
    output logic                        wb_valid,
    input  wire                         wb_ready,
    input  wire                         wb_flush,
    output lsu_pkg::lsu_wb_t            wb
);
    import lsu_pkg::*;

    bus_err_t               load_err;
    bus_err_t               store_err;
    logic                   misaligned;
    logic                   trap_valid;
    logic [`LSU_XLEN-1:0]   trap_cause;
    logic [`LSU_XLEN-1:0]   trap_tval;
    logic                   load_done;
    logic [`LSU_XLEN-1:0]   load_data;
    logic                   store_done;

    lsu_exception_unit u_exception (
        .req        (ex_req),
        .ex_valid   (ex_valid),
        .load_err   (load_err),
        .store_err  (store_err),
        .misaligned (misaligned),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .trap_tval  (trap_tval)
    );

    lsu_load_path u_load (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .req        (ex_req),
        .misaligned (misaligned),
        .accept     (ex_ready),
        .ar_ready   (ar_ready),
        .r_valid    (r_valid),
        .r_resp     (r_resp),
        .r_data     (r_data),
        .ar_valid   (ar_valid),
        .ar         (ar),
        .load_done  (load_done),
        .load_data  (load_data),
        .load_err   (load_err)
    );

    lsu_store_path u_store (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .req        (ex_req),
        .misaligned (misaligned),
        .accept     (ex_ready),
        .aw_ready   (aw_ready),
        .w_ready    (w_ready),
        .b_valid    (b_valid),
        .b_resp     (b_resp),
        .aw_valid   (aw_valid),
        .w_valid    (w_valid),
        .wr         (wr),
        .store_done (store_done),
        .store_err  (store_err)
    );

    lsu_commit_stage u_commit (
        .clk        (clk),
        .rst_n      (rst_n),
        .ex_valid   (ex_valid),
        .req        (ex_req),
        .load_done  (load_done),
        .load_data  (load_data),
        .store_done (store_done),
        .trap_valid (trap_valid),
        .trap_cause (trap_cause),
        .trap_tval  (trap_tval),
        .wb_ready   (wb_ready),
        .wb_flush   (wb_flush),
        .ex_ready   (ex_ready),
        .wb_valid   (wb_valid),
        .wb         (wb)
    );

endmodule

`default_nettype wire

//--- tests/lsu_assertions.sv
`timescale 1ns/10ps
`default_nettype none

module lsu_assertions (
    input wire clk,
    input wire rst_n,
    input wire ar_valid,
    input wire ar_ready,
    input wire aw_valid,
    input wire aw_ready,
    input wire w_valid,
    input wire w_ready,
    input wire wb_valid
);

    // valids hold until their ready
    assert property (@(posedge clk) disable iff (!rst_n) ar_valid && !ar_ready |=> ar_valid)
        else $error("ar_valid dropped before ar_ready");
    assert property (@(posedge clk) disable iff (!rst_n) aw_valid && !aw_ready |=> aw_valid)
        else $error("aw_valid dropped before aw_ready");
    assert property (@(posedge clk) disable iff (!rst_n) w_valid && !w_ready |=> w_valid)
        else $error("w_valid dropped before w_ready");

    // one operation in flight
    assert property (@(posedge clk) disable iff (!rst_n) !(ar_valid && aw_valid))
        else $error("read and write address valid together");

    assert property (@(posedge clk) !rst_n |-> !ar_valid && !aw_valid && !w_valid && !wb_valid)
        else $error("valid high during reset");

endmodule

bind lsu lsu_assertions lsu_assertions_inst (.*);

`default_nettype wire

//--- tests/lsu_tb.sv
`timescale 1ns/10ps
`default_nettype none

`include "lsu_macros.svh"

module lsu_tb;
    import lsu_pkg::*;

    typedef struct {
        string          name;
        int             kind;       // 0 pass-through, 1 load, 2 store
        mem_size_t      size;
        logic           is_signed;
        logic [63:0]    addr;
        logic [63:0]    sdata;
        logic [1:0]     resp;
        int             stall;
        logic [63:0]    exp_data;
        logic           exp_trap;
        logic [63:0]    exp_cause;
    } row_t;

    logic clk = 1'b0;
    logic rst_n = 1'b0;
    logic ex_valid = 1'b0;
    lsu_req_t ex_req = '0;
    logic ex_ready, ar_valid, aw_valid, w_valid, wb_valid;
    logic ar_ready = 1'b0;
    logic aw_ready = 1'b0;
    logic w_ready = 1'b0;
    logic r_valid = 1'b0;
    logic b_valid = 1'b0;
    logic [1:0] r_resp = 2'd0;
    logic [1:0] b_resp = 2'd0;
    logic [63:0] r_data = '0;
    logic wb_ready = 1'b1;
    logic wb_flush = 1'b0;
    rd_addr_t ar;
    wr_req_t wr;
    lsu_wb_t wb;

    row_t rows[$];
    string cur_name = "";
    logic [63:0] mem [8];
    logic [63:0] rng_state = 64'd25;
    logic [1:0] cur_resp = 2'd0;
    logic [63:0] rd_addr;
    wr_req_t wr_cap;
    logic rd_pending = 1'b0;
    logic aw_done = 1'b0;
    logic w_done = 1'b0;
    logic [1:0] ar_wait = 2'd0;
    logic [1:0] r_wait = 2'd0;
    logic [1:0] aw_wait = 2'd0;
    logic [1:0] w_wait = 2'd0;
    logic [1:0] b_wait = 2'd0;
    int cycles = 0;

    lsu lsu_inst (.*);

    always #20 clk = ~clk;

    function automatic logic [63:0] xorshift(input logic [63:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 7);
        s = s ^ (s << 17);
        return s;
    endfunction

    function automatic logic [1:0] next_delay();
        rng_state = xorshift(rng_state);
        return rng_state[1:0];
    endfunction

    // **********************************************************************
    // bus responder driven 1 ns after each edge
    // **********************************************************************
    always @(posedge clk) begin
        #1;
        if (r_valid) begin
            r_valid = 1'b0;
        end else if (rd_pending) begin
            if (r_wait == 0) begin
                r_valid = 1'b1;
                r_data = mem[rd_addr[5:3]];
                r_resp = cur_resp;
                rd_pending = 1'b0;
            end else begin
                r_wait = r_wait - 1;
            end
        end
        if (ar_ready) begin
            ar_ready = 1'b0;
        end else if (ar_valid) begin
            if (ar_wait == 0) begin
                ar_ready = 1'b1;
                rd_addr = ar.addr;
                rd_pending = 1'b1;
                r_wait = next_delay();
                check({cur_name, ".ar_addr"}, ex_req.operand, ar.addr);
                check({cur_name, ".ar_size"}, ex_req.size, ar.size);
            end else begin
                ar_wait = ar_wait - 1;
            end
        end else begin
            ar_wait = next_delay();
        end
        if (b_valid) begin
            b_valid = 1'b0;
        end else if (aw_done && w_done) begin
            if (b_wait == 0) begin
                // memory is only written on an okay response
                for (int b = 0; b < 8; b++) begin
                    if (wr_cap.strb[b] && cur_resp == `LSU_RESP_OKAY) begin
                        mem[wr_cap.addr[5:3]][8*b +: 8] = wr_cap.data[8*b +: 8];
                    end
                end
                b_valid = 1'b1;
                b_resp = cur_resp;
                aw_done = 1'b0;
                w_done = 1'b0;
            end else begin
                b_wait = b_wait - 1;
            end
        end
        if (aw_ready) begin
            aw_ready = 1'b0;
            aw_done = 1'b1;
            b_wait = next_delay();
        end else if (aw_valid) begin
            if (aw_wait == 0) begin
                aw_ready = 1'b1;
                wr_cap = wr;
                check({cur_name, ".aw_addr"}, ex_req.operand, wr.addr);
                check({cur_name, ".aw_size"}, ex_req.size, wr.size);
            end else begin
                aw_wait = aw_wait - 1;
            end
        end else begin
            aw_wait = next_delay();
        end
        if (w_ready) begin
            w_ready = 1'b0;
            w_done = 1'b1;
        end else if (w_valid) begin
            if (w_wait == 0) begin
                w_ready = 1'b1;
            end else begin
                w_wait = w_wait - 1;
            end
        end else begin
            w_wait = next_delay();
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (rows.size() > 0 && cycles >= rows.size() * 40 + 50) begin
            $display("run timed out waiting for the DUT");
            $display("TESTS FAILED");
            $fatal(1);
        end
    end

    task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (exp !== act) begin
            $display("mismatch %s: expected %h, actual %h", name, exp, act);
            $display("TESTS FAILED");
            $fatal(1);
        end
    endtask

    task automatic add_row(input string name, input int kind, input mem_size_t size,
                           input logic sgn, input logic [63:0] addr, input logic [63:0] sdata,
                           input logic [1:0] resp, input int stall, input logic [63:0] exp_data,
                           input logic exp_trap, input logic [63:0] exp_cause);
        row_t r;
        r = '{name, kind, size, sgn, addr, sdata, resp, stall, exp_data, exp_trap, exp_cause};
        rows.push_back(r);
    endtask

    task automatic run_row(input int i);
        row_t r;
        logic bus_seen;
        logic exp_bus;
        lsu_wb_t snap;
        r = rows[i];
        cur_name = r.name;
        bus_seen = 1'b0;
        exp_bus = r.kind != 0 && !(r.exp_trap && (r.exp_cause == 4 || r.exp_cause == 6));
        ex_req = '0;
        ex_req.pc = 64'h1000 + 64'(i) * 4;
        ex_req.rd = 5'(i);
        ex_req.dest_wen = (i % 2) == 0;
        ex_req.is_load = r.kind == 1;
        ex_req.is_store = r.kind == 2;
        ex_req.size = r.size;
        ex_req.is_signed = r.is_signed;
        ex_req.operand = r.addr;
        ex_req.store_data = r.sdata;
        cur_resp = r.resp;
        ex_valid = 1'b1;
        do begin
            @(negedge clk);
            if (ar_valid || aw_valid) bus_seen = 1'b1;
        end while (!ex_ready);
        @(posedge clk);
        #1;
        if (ar_valid || aw_valid) bus_seen = 1'b1;
        ex_valid = 1'b0;
        check({r.name, ".wb_valid"}, 1, wb_valid);
        check({r.name, ".pc"}, ex_req.pc, wb.pc);
        check({r.name, ".rd"}, ex_req.rd, wb.rd);
        check({r.name, ".dest_wen"}, ex_req.dest_wen, wb.dest_wen);
        check({r.name, ".bus"}, exp_bus, bus_seen);
        check({r.name, ".trap"}, r.exp_trap, wb.trap_valid);
        if (r.exp_trap) begin
            check({r.name, ".cause"}, r.exp_cause, wb.trap_cause);
            check({r.name, ".tval"}, r.addr, wb.trap_tval);
        end else begin
            check({r.name, ".data"}, r.exp_data, wb.data);
        end
        if (r.stall > 0) begin
            // a second op waits behind the stalled result
            snap = wb;
            wb_ready = 1'b0;
            ex_req.is_load = 1'b0;
            ex_req.is_store = 1'b0;
            ex_req.pc = ex_req.pc + 64'h4;
            ex_req.operand = ~r.addr;
            ex_valid = 1'b1;
            repeat (r.stall) begin
                @(negedge clk);
                check({r.name, ".stall_ready"}, 0, ex_ready);
                check({r.name, ".stall_wb"}, 1, wb == snap);
                @(posedge clk);
                #1;
            end
            ex_valid = 1'b0;
            wb_flush = 1'b1;
            @(posedge clk);
            #1;
            wb_flush = 1'b0;
            wb_ready = 1'b1;
            check({r.name, ".flush"}, 0, wb_valid);
        end
    endtask

    initial begin
        // byte at address a holds {a[0], 0, a[5:0]}
        for (int a = 0; a < 64; a++) begin
            mem[a >> 3][8*(a & 7) +: 8] = {a[0], 1'b0, a[5:0]};
        end
        add_row("lb_odd", 1, SIZE_BYTE, 1, 1, 0, 0, 0, 64'hffffffffffffff81, 0, 0);
        add_row("lbu_odd", 1, SIZE_BYTE, 0, 1, 0, 0, 0, 64'h81, 0, 0);
        add_row("lb_pos", 1, SIZE_BYTE, 1, 6, 0, 0, 0, 64'h06, 0, 0);
        add_row("lh", 1, SIZE_HALF, 1, 2, 0, 0, 0, 64'hffffffffffff8302, 0, 0);
        add_row("lhu", 1, SIZE_HALF, 0, 6, 0, 0, 0, 64'h8706, 0, 0);
        add_row("lw", 1, SIZE_WORD, 1, 4, 0, 0, 0, 64'hffffffff87068504, 0, 0);
        add_row("lwu", 1, SIZE_WORD, 0, 12, 0, 0, 0, 64'h8f0e8d0c, 0, 0);
        add_row("ld", 1, SIZE_DOUBLE, 0, 8, 0, 0, 0, 64'h8f0e8d0c8b0a8908, 0, 0);
        add_row("lb_o0", 1, SIZE_BYTE, 1, 8, 0, 0, 0, 64'h08, 0, 0);
        add_row("lbu_o2", 1, SIZE_BYTE, 0, 10, 0, 0, 0, 64'h0a, 0, 0);
        add_row("lb_o3", 1, SIZE_BYTE, 1, 11, 0, 0, 0, 64'hffffffffffffff8b, 0, 0);
        add_row("lbu_o4", 1, SIZE_BYTE, 0, 12, 0, 0, 0, 64'h0c, 0, 0);
        add_row("lb_o5", 1, SIZE_BYTE, 1, 13, 0, 0, 0, 64'hffffffffffffff8d, 0, 0);
        add_row("lbu_o7", 1, SIZE_BYTE, 0, 15, 0, 0, 0, 64'h8f, 0, 0);
        add_row("lhu_o0", 1, SIZE_HALF, 0, 8, 0, 0, 0, 64'h8908, 0, 0);
        add_row("lh_o4", 1, SIZE_HALF, 1, 12, 0, 0, 0, 64'hffffffffffff8d0c, 0, 0);
        add_row("lw_o0", 1, SIZE_WORD, 1, 8, 0, 0, 0, 64'hffffffff8b0a8908, 0, 0);
        add_row("sb", 2, SIZE_BYTE, 0, 17, 64'hab, 0, 0, 17, 0, 0);
        add_row("sh", 2, SIZE_HALF, 0, 20, 64'hcdef, 0, 0, 20, 0, 0);
        add_row("ld_sb_sh", 1, SIZE_DOUBLE, 0, 16, 0, 0, 0, 64'h9716cdef9312ab10, 0, 0);
        add_row("sw", 2, SIZE_WORD, 0, 28, 64'h11223344, 0, 0, 28, 0, 0);
        add_row("ld_sw", 1, SIZE_DOUBLE, 0, 24, 0, 0, 0, 64'h112233449b1a9918, 0, 0);
        add_row("sd", 2, SIZE_DOUBLE, 0, 32, 64'h0123456789abcdef, 0, 0, 32, 0, 0);
        add_row("ld_sd", 1, SIZE_DOUBLE, 0, 32, 0, 0, 0, 64'h0123456789abcdef, 0, 0);
        add_row("lh_mis", 1, SIZE_HALF, 1, 3, 0, 0, 0, 0, 1, 4);
        add_row("sw_mis", 2, SIZE_WORD, 0, 18, 64'h55, 0, 0, 0, 1, 6);
        add_row("ld_page", 1, SIZE_DOUBLE, 0, 40, 0, `LSU_RESP_PAGE_ERR, 0, 0, 1, 13);
        add_row("ld_acc", 1, SIZE_DOUBLE, 0, 48, 0, `LSU_RESP_ACCESS_ERR, 0, 0, 1, 5);
        add_row("sd_page", 2, SIZE_DOUBLE, 0, 40, 1, `LSU_RESP_PAGE_ERR, 0, 0, 1, 15);
        add_row("sd_acc", 2, SIZE_DOUBLE, 0, 48, 2, `LSU_RESP_ACCESS_ERR, 0, 0, 1, 7);
        add_row("pass_stall", 0, SIZE_BYTE, 0, 64'hdeadbeef, 0, 0, 3, 64'hdeadbeef, 0, 0);
        add_row("pass", 0, SIZE_BYTE, 0, 64'h123, 0, 0, 0, 64'h123, 0, 0);
        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            run_row(i);
        end
        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+hdl
hdl/lsu_pkg.sv
hdl/lsu_exception_unit.sv
hdl/lsu_load_path.sv
hdl/lsu_store_path.sv
hdl/lsu_commit_stage.sv
hdl/lsu.sv
tests/lsu_assertions.sv
tests/lsu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the LSU testbench with Verilator.
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wall -Wno-fatal \
    -f vlog.f --top-module lsu_tb -o Vlsu_tb
./obj_dir/Vlsu_tb
